// ==== verilog/uart_cmd_defines.svh ====
`ifndef UART_CMD_DEFINES_SVH
`define UART_CMD_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define UART_CMD_W    16
`define UART_BYTE_W   8
`define UART_DIV_W    16
`define UART_GAP_W    8
`define UART_TMO_W    16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration reset values and limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define UART_DIV_RST  16'd434
`define UART_GAP_RST  8'd100
`define UART_TMO_RST  16'd65535
// Shortest bit period, in clocks
`define UART_DIV_MIN  16'd4

// Configuration register map
`define UART_CFG_DIV  2'd0
`define UART_CFG_GAP  2'd1
`define UART_CFG_TMO  2'd2

`endif

// ==== verilog/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command sequencer states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    SEND_HI    = 3'd1,
    GAP        = 3'd2,
    SEND_LO    = 3'd3,
    WAIT_REPLY = 3'd4,
    RECV_REPLY = 3'd5
  } seq_state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outcome of one received frame
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    RX_OK      = 2'd0,
    RX_PARITY  = 2'd1,
    RX_FRAMING = 2'd2
  } rx_result_t;

endpackage

// ==== verilog/uart_cfg_regs.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cfg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_we,
  input  logic [1:0]             cfg_addr,
  input  logic [`UART_DIV_W-1:0] cfg_wdata,
  output logic [`UART_DIV_W-1:0] cfg_rdata,
  output logic [`UART_DIV_W-1:0] bit_div,
  output logic [`UART_GAP_W-1:0] gap_clks,
  output logic [`UART_TMO_W-1:0] tmo_clks
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_div  <= `UART_DIV_RST;
      gap_clks <= `UART_GAP_RST;
      tmo_clks <= `UART_TMO_RST;
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        // Too short a period leaves no room for mid-bit sampling
        `UART_CFG_DIV: bit_div <= (cfg_wdata < `UART_DIV_MIN) ? `UART_DIV_MIN : cfg_wdata;
        `UART_CFG_GAP: gap_clks <= cfg_wdata[`UART_GAP_W-1:0];
        `UART_CFG_TMO: tmo_clks <= cfg_wdata[`UART_TMO_W-1:0];
        default: ;
      endcase
    end
  end

  // Readback
  always_comb
  begin
    case (cfg_addr)
      `UART_CFG_DIV: cfg_rdata = bit_div;
      `UART_CFG_GAP: cfg_rdata = {{(`UART_DIV_W-`UART_GAP_W){1'b0}}, gap_clks};
      `UART_CFG_TMO: cfg_rdata = tmo_clks;
      default:       cfg_rdata = '0;
    endcase
  end

endmodule

// ==== verilog/uart_tx_frame.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_tx_frame (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_DIV_W-1:0]  bit_div,
  input  logic                    tx_start,
  input  logic [`UART_BYTE_W-1:0] tx_byte,
  output logic                    tx,
  output logic                    tx_busy,
  output logic                    tx_done
);

  // Bit 0 is start, 1..8 data, 9 parity, 10 stop
  localparam logic [3:0] STOP_BIT = 4'd10;

  logic [`UART_DIV_W-1:0]  div_cnt;
  logic [3:0]              bit_idx;
  logic [`UART_BYTE_W+1:0] frame_q;
  logic                    bit_end;

  assign bit_end = (div_cnt == bit_div - 1'b1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bits still to send after the start bit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      // Stop, odd parity, data
      frame_q <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_end)
    begin
      frame_q <= {1'b1, frame_q[`UART_BYTE_W+1:1]};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit timing and line drive
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      div_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (!tx_busy)
      begin
        if (tx_start)
        begin
          tx      <= 1'b0;
          tx_busy <= 1'b1;
          div_cnt <= '0;
          bit_idx <= '0;
        end
      end
      else if (bit_end)
      begin
        div_cnt <= '0;
        if (bit_idx == STOP_BIT)
        begin
          tx      <= 1'b1;
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end
        else
        begin
          tx      <= frame_q[0];
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/uart_rx_frame.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_rx_frame (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`UART_DIV_W-1:0]    bit_div,
  input  logic                      rx,
  output logic                      rx_busy,
  output logic                      rx_valid,
  output logic [`UART_BYTE_W-1:0]   rx_byte,
  output uart_cmd_pkg::rx_result_t  rx_result
);

  import uart_cmd_pkg::*;

  localparam logic [3:0] START_BIT  = 4'd0;
  localparam logic [3:0] PARITY_BIT = 4'd9;
  localparam logic [3:0] STOP_BIT   = 4'd10;

  logic                    rx_s1;
  logic                    rx_s2;
  logic                    rx_d;
  logic [`UART_DIV_W-1:0]  cnt;
  logic [3:0]              bit_idx;
  logic [`UART_BYTE_W-1:0] data_q;
  logic                    par_q;
  logic                    sample;
  logic                    start_edge;

  assign start_edge = !rx_busy && rx_d && !rx_s2;
  assign sample     = rx_busy && (cnt == '0);
  assign rx_byte    = data_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Synchronizer and edge history
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  // Data and parity capture
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx > START_BIT && bit_idx < PARITY_BIT)
        data_q <= {rx_s2, data_q[`UART_BYTE_W-1:1]};
      else if (bit_idx == PARITY_BIT)
        par_q <= rx_s2;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Mid-bit timing and frame check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy   <= 1'b0;
      rx_valid  <= 1'b0;
      rx_result <= RX_OK;
      cnt       <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (start_edge)
      begin
        // First sample lands half a bit after the edge
        rx_busy <= 1'b1;
        bit_idx <= START_BIT;
        cnt     <= (bit_div >> 1) - 1'b1;
      end
      else if (rx_busy)
      begin
        if (cnt != '0)
        begin
          cnt <= cnt - 1'b1;
        end
        else
        begin
          cnt <= bit_div - 1'b1;
          if (bit_idx == START_BIT && rx_s2)
          begin
            // Glitch, no report
            rx_busy <= 1'b0;
          end
          else if (bit_idx == STOP_BIT)
          begin
            rx_busy  <= 1'b0;
            rx_valid <= 1'b1;
            if (!rx_s2)
              rx_result <= RX_FRAMING;
            else if (!(^{data_q, par_q}))
              rx_result <= RX_PARITY;
            else
              rx_result <= RX_OK;
          end
          else
          begin
            bit_idx <= bit_idx + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== verilog/uart_cmd_seq.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cmd_seq (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`UART_CMD_W-1:0]    cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  input  logic [`UART_GAP_W-1:0]    gap_clks,
  input  logic [`UART_TMO_W-1:0]    tmo_clks,
  output logic                      tx_start,
  output logic [`UART_BYTE_W-1:0]   tx_byte,
  input  logic                      tx_done,
  input  logic                      rx_busy,
  input  logic                      rx_valid,
  input  logic [`UART_BYTE_W-1:0]   rx_byte,
  input  uart_cmd_pkg::rx_result_t  rx_result,
  output logic                      read_done,
  output logic [`UART_BYTE_W-1:0]   read_data,
  output logic                      read_err
);

  import uart_cmd_pkg::*;

  // Gap count already covers the tx_done, GAP entry and tx_start clocks
  localparam logic [`UART_GAP_W-1:0] GAP_PRESET = 3;

  seq_state_t             state;
  logic [`UART_CMD_W-1:0] cmd_q;
  logic [`UART_GAP_W-1:0] gap_cnt;
  logic [`UART_TMO_W-1:0] tmo_cnt;
  logic                   cmd_acc;
  logic                   is_write;

  assign cmd_rdy  = (state == IDLE);
  assign cmd_acc  = cmd_vld && cmd_rdy;
  assign is_write = cmd_q[`UART_CMD_W-1];
  assign tx_byte  = (state == SEND_LO) ? cmd_q[`UART_BYTE_W-1:0]
                                       : cmd_q[`UART_CMD_W-1:`UART_BYTE_W];

  always_ff @(posedge clk)
  begin
    if (cmd_acc)
      cmd_q <= cmd_in;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      tx_start  <= 1'b0;
      gap_cnt   <= '0;
      tmo_cnt   <= '0;
      read_done <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start  <= 1'b0;
      read_done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (cmd_acc)
          begin
            tx_start <= 1'b1;
            state    <= SEND_HI;
          end
        end
        SEND_HI:
        begin
          if (tx_done)
          begin
            if (is_write)
            begin
              gap_cnt <= GAP_PRESET;
              state   <= GAP;
            end
            else
            begin
              tmo_cnt <= '0;
              state   <= WAIT_REPLY;
            end
          end
        end
        GAP:
        begin
          if (gap_cnt >= gap_clks)
          begin
            tx_start <= 1'b1;
            state    <= SEND_LO;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        SEND_LO:
        begin
          if (tx_done)
            state <= IDLE;
        end
        WAIT_REPLY:
        begin
          if (rx_busy)
            state <= RECV_REPLY;
          else if (tmo_cnt >= tmo_clks)
          begin
            read_done <= 1'b1;
            read_data <= '0;
            read_err  <= 1'b1;
            state     <= IDLE;
          end
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        end
        RECV_REPLY:
        begin
          if (rx_valid)
          begin
            read_done <= 1'b1;
            read_data <= rx_byte;
            read_err  <= (rx_result != RX_OK);
            state     <= IDLE;
          end
          else if (!rx_busy)
          begin
            // Start glitch, keep waiting on the same timeout
            state <= WAIT_REPLY;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/uart_cmd_master.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cmd_master (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_CMD_W-1:0]  cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    read_done,
  output logic [`UART_BYTE_W-1:0] read_data,
  output logic                    read_err,
  input  logic                    cfg_we,
  input  logic [1:0]              cfg_addr,
  input  logic [`UART_DIV_W-1:0]  cfg_wdata,
  output logic [`UART_DIV_W-1:0]  cfg_rdata,
  output logic                    tx,
  input  logic                    rx
);

  import uart_cmd_pkg::*;

  logic [`UART_DIV_W-1:0]  bit_div;
  logic [`UART_GAP_W-1:0]  gap_clks;
  logic [`UART_TMO_W-1:0]  tmo_clks;
  logic                    tx_start;
  logic [`UART_BYTE_W-1:0] tx_byte;
  logic                    tx_done;
  logic                    rx_busy;
  logic                    rx_valid;
  logic [`UART_BYTE_W-1:0] rx_byte;
  rx_result_t              rx_result;

  uart_cfg_regs u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .bit_div   (bit_div),
    .gap_clks  (gap_clks),
    .tmo_clks  (tmo_clks)
  );

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .gap_clks  (gap_clks),
    .tmo_clks  (tmo_clks),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_result (rx_result),
    .read_done (read_done),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .bit_div  (bit_div),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (),
    .tx_done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .bit_div   (bit_div),
    .rx        (rx),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_result (rx_result)
  );

endmodule

// ==== verification/uart_slave_model.sv ====
`timescale 1ns/10ps

module uart_slave_model (
  input  logic clk,
  input  logic line_in,
  output logic line_out,
  input  int   bit_clks,
  input  logic flip_parity,
  input  logic silent,
  output int   frame_cnt,
  output int   err_cnt
);

  logic [7:0] regs [0:127];

  task automatic bit_error(input string name, input int exp, input int act);
    err_cnt = err_cnt + 1;
    $display("ERROR %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame receive and send
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic recv_byte(output logic [7:0] b);
    logic par;
    logic prev;
    // Start edge needs the line seen idle high first
    prev = 1'b0;
    while (!(prev === 1'b1 && line_in === 1'b0))
    begin
      prev = line_in;
      @(negedge clk);
    end
    repeat (bit_clks / 2) @(negedge clk);
    start_low: assert (line_in == 1'b0)
      else bit_error("tx start bit", 0, int'(line_in));
    for (int i = 0; i < 8; i++)
    begin
      repeat (bit_clks) @(negedge clk);
      b[i] = line_in;
    end
    repeat (bit_clks) @(negedge clk);
    par = line_in;
    odd_parity: assert ((^{b, par}) == 1'b1)
      else bit_error("tx parity bit", int'(~^b), int'(par));
    repeat (bit_clks) @(negedge clk);
    stop_high: assert (line_in == 1'b1)
      else bit_error("tx stop bit", 1, int'(line_in));
    frame_cnt = frame_cnt + 1;
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ flip_parity, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      #1;
      line_out = frame[i];
      repeat (bit_clks - 1) @(posedge clk);
    end
  endtask

  initial
  begin
    logic [7:0] hi;
    logic [7:0] lo;
    line_out  = 1'b1;
    frame_cnt = 0;
    err_cnt   = 0;
    for (int i = 0; i < 128; i++)
      regs[i] = 8'(i * 5) ^ 8'ha3;
    forever
    begin
      recv_byte(hi);
      if (hi[7])
      begin
        recv_byte(lo);
        regs[hi[6:0]] = lo;
      end
      else if (!silent)
      begin
        // Reply after about three bit times
        repeat (3 * bit_clks) @(posedge clk);
        send_byte(regs[hi[6:0]]);
      end
    end
  end

endmodule

// ==== verification/uart_cmd_tb.sv ====
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cmd_tb;

  // Clocks allowed for any single wait
  localparam int WAIT_LIMIT = 5000;

  logic                    clk;
  logic                    rst_n;
  logic [`UART_CMD_W-1:0]  cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    read_done;
  logic [`UART_BYTE_W-1:0] read_data;
  logic                    read_err;
  logic                    cfg_we;
  logic [1:0]              cfg_addr;
  logic [`UART_DIV_W-1:0]  cfg_wdata;
  logic [`UART_DIV_W-1:0]  cfg_rdata;
  logic                    tx;
  logic                    rx;
  int                      bit_clks;
  logic                    flip_parity;
  logic                    silent;
  int                      frame_cnt;
  int                      model_errs;
  int                      errors;
  int                      done_cnt;
  logic [7:0]              shadow [0:127];
  logic [6:0]              written [$];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  uart_cmd_master u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_done (read_done),
    .read_data (read_data),
    .read_err  (read_err),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .tx        (tx),
    .rx        (rx)
  );

  uart_slave_model u_slave (
    .clk         (clk),
    .line_in     (tx),
    .line_out    (rx),
    .bit_clks    (bit_clks),
    .flip_parity (flip_parity),
    .silent      (silent),
    .frame_cnt   (frame_cnt),
    .err_cnt     (model_errs)
  );

  always @(negedge clk)
  begin
    if (read_done === 1'b1)
      done_cnt = done_cnt + 1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  read_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_done |=> !read_done)
    else
    begin
      errors = errors + 1;
      $display("ERROR %0t: read_done expected 0x0, got 0x1", $time);
    end

  rdy_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    read_done |-> cmd_rdy)
    else
    begin
      errors = errors + 1;
      $display("ERROR %0t: cmd_rdy expected 0x1, got 0x0", $time);
    end

  task automatic check_value(input string name, input int exp, input int act);
    value_match: assert (act == exp)
      else
      begin
        errors = errors + 1;
        $display("ERROR %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      end
  endtask

  task automatic wait_cmd_rdy();
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
    begin
      errors = errors + 1;
      $display("Timeout: cmd_rdy never came back, sequencer stuck in %s",
               u_dut.u_seq.state.name());
    end
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic cfg_check(input logic [1:0] addr, input int exp);
    @(posedge clk);
    #1;
    cfg_addr = addr;
    @(negedge clk);
    check_value("cfg_rdata", exp, int'(cfg_rdata));
  endtask

  task automatic send_cmd(input logic [15:0] cmd);
    wait_cmd_rdy();
    @(posedge clk);
    #1;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register commands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
    int frames0;
    frames0 = frame_cnt;
    send_cmd({1'b1, addr, data});
    shadow[addr] = data;
    written.push_back(addr);
    wait_cmd_rdy();
    check_value("frames per write", frames0 + 2, frame_cnt);
    check_value("slave register", int'(data), int'(u_slave.regs[addr]));
  endtask

  task automatic read_reg(input logic [6:0] addr, input logic exp_err,
                          input logic check_data, input int exp_data, input logic poke);
    int n;
    int frames0;
    int done0;
    frames0 = frame_cnt;
    done0   = done_cnt;
    send_cmd({1'b0, addr, 8'($urandom)});
    if (poke)
    begin
      // Write strobe while busy, must be dropped
      check_value("cmd_rdy", 0, int'(cmd_rdy));
      cmd_in  = {1'b1, addr, ~shadow[addr]};
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
    end
    n = 0;
    while (read_done !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (read_done !== 1'b1)
    begin
      errors = errors + 1;
      $display("Timeout: no read_done for address 0x%0h, sequencer in %s",
               addr, u_dut.u_seq.state.name());
    end
    else
    begin
      check_value("read_err", int'(exp_err), int'(read_err));
      if (check_data)
        check_value("read_data", exp_data, int'(read_data));
      if (check_data && !exp_err)
        check_value("slave register", int'(u_slave.regs[addr]), int'(read_data));
    end
    wait_cmd_rdy();
    repeat (4) @(negedge clk);
    check_value("read_done count", done0 + 1, done_cnt);
    check_value("frames per read", frames0 + 1, frame_cnt);
  endtask

  initial
  begin
    logic [6:0] addr;
    logic [7:0] data;
    void'($urandom(32'h45de));
    errors      = 0;
    done_cnt    = 0;
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    bit_clks    = 8;
    flip_parity = 1'b0;
    silent      = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("tx", 1, int'(tx));
    check_value("cmd_rdy", 1, int'(cmd_rdy));
    check_value("read_done", 0, int'(read_done));

    // Setup, then readback
    cfg_write(`UART_CFG_DIV, 16'd8);
    cfg_write(`UART_CFG_GAP, 16'd10);
    cfg_write(`UART_CFG_TMO, 16'd60);
    cfg_check(`UART_CFG_GAP, 10);
    cfg_check(`UART_CFG_TMO, 60);
    cfg_write(`UART_CFG_DIV, 16'd2);
    cfg_check(`UART_CFG_DIV, 4);
    cfg_check(2'd3, 0);
    cfg_write(`UART_CFG_DIV, 16'd8);
    cfg_check(`UART_CFG_DIV, 8);

    for (int i = 0; i < 6; i++)
    begin
      addr = 7'($urandom);
      data = 8'($urandom);
      write_reg(addr, data);
    end
    foreach (written[i])
      read_reg(written[i], 1'b0, 1'b1, int'(shadow[written[i]]), 1'b0);

    // Corrupted and missing replies
    flip_parity = 1'b1;
    read_reg(written[0], 1'b1, 1'b0, 0, 1'b0);
    flip_parity = 1'b0;
    silent = 1'b1;
    read_reg(written[1], 1'b1, 1'b1, 0, 1'b0);
    silent = 1'b0;

    read_reg(written[2], 1'b0, 1'b1, int'(shadow[written[2]]), 1'b1);
    read_reg(written[2], 1'b0, 1'b1, int'(shadow[written[2]]), 1'b0);

    repeat (4) @(negedge clk);
    $display("Error count: %0d testbench, %0d slave model", errors, model_errs);
    if (errors == 0 && model_errs == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/uart_cmd_pkg.sv
verilog/uart_cfg_regs.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_seq.sv
verilog/uart_cmd_master.sv
verification/uart_slave_model.sv
verification/uart_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module uart_cmd_tb -o uart_cmd_sim
out=$(./obj_dir/uart_cmd_sim)
echo "$out"

if echo "$out" | grep -q "Finished with no errors"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
